//--- ks10Mem.f
common/ks10MemPkg.sv
verilog/mem/memTiming.sv
verilog/mem/memStat.sv
verilog/mem/memArray.sv
verilog/mem/memCtrl.sv
verilog/ks10Mem.sv
verif/ks10MemTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ks10MemTb -f ks10Mem.f

if ! ./obj_dir/Vks10MemTb > sim.log 2>&1
then
   cat sim.log
   echo "simulation exited with an error"
   exit 1
fi

cat sim.log
if grep -q "TESTS FAILED" sim.log
then
   exit 1
fi

//--- verif/ks10MemTb.sv
// Directed testbench for the memory subsystem with bus cycle tasks and a reference model
`default_nettype none
`timescale 1ns/1ps

module ks10MemTb
   import ks10MemPkg::*;
();

   localparam int memAddrWidth = 15;
   // Bus cycles issued by all tests, reset check counted as two
   localparam int busCycles  = 114;
   localparam int cycleLimit = 2 * busCycles * 4 + 100;

   logic     clkT;
   logic     rst;
   logic     busReq;
   busAddr_u busAddr;
   word_t    busDataIn;
   logic     busAck;
   word_t    busDataOut;
   phase_t   phase;

   int          errorCount;
   int          testCount;
   int          failedTests;
   int          cycleCount;
   int          testErrStart;
   logic [31:0] rngState;

   // Reference model
   word_t       shadowMem [int];
   word_t       shadowHsb [0:31];
   word_t       shadowMsr;
   logic [21:0] usedAddr [$];

   ks10Mem #(
      .memAddrWidth (memAddrWidth)
   ) uut (
      .clkT       (clkT),
      .rst        (rst),
      .busReq     (busReq),
      .busAddr    (busAddr),
      .busDataIn  (busDataIn),
      .busAck     (busAck),
      .busDataOut (busDataOut),
      .phase      (phase)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Clock and run limit
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      clkT = 1'b0;
      forever #5 clkT = ~clkT;
   end

   always @(posedge clkT)
   begin
      cycleCount++;
      if (cycleCount >= cycleLimit)
      begin
         $display("ERROR: run did not finish within %0d cycles", cycleLimit);
         $display("TESTS FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   // 32-bit xorshift
   function automatic logic [31:0] nextRandom();
      rngState = rngState ^ (rngState << 13);
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState;
   endfunction

   function automatic word_t randomWord();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = nextRandom();
      lo = nextRandom();
      return {hi[3:0], lo};
   endfunction

   // Memory reference, one flag plus a 22-bit address
   function automatic word_t memAddrWord(input int unsigned flag, input logic [21:0] addr);
      word_t w;
      w       = '0;
      w[flag] = 1'b1;
      w[14:35] = addr;
      return w;
   endfunction

   // Physical I/O reference to a device register
   function automatic word_t ioAddrWord(input int unsigned flag, input logic [3:0] dev,
                                        input logic [17:0] addr);
      word_t w;
      w           = '0;
      w[flag]     = 1'b1;
      w[flagIo]   = 1'b1;
      w[flagPhys] = 1'b1;
      w[14:17]    = dev;
      w[18:35]    = addr;
      return w;
   endfunction

   task automatic reportWrong(input string testName, input word_t expected,
                              input word_t actual);
      $display("FAILED %s: expected %o, actual %o", testName, expected, actual);
      errorCount++;
   endtask

   task automatic startTest();
      testErrStart = errorCount;
      testCount++;
   endtask

   task automatic finishTest(input string testName);
      if (errorCount == testErrStart)
      begin
         $display("test %s: ok", testName);
      end
      else
      begin
         failedTests++;
         $display("test %s: %0d errors", testName, errorCount - testErrStart);
      end
   endtask

   // One full T1-T4 bus cycle
   // Starts and ends 1 ns after a rising edge
   task automatic busCycle(input word_t addrWord, input word_t wrData,
                           output logic ack, output word_t rdData);
      // Line up on T1
      while (phase !== phaseT1)
      begin
         @(posedge clkT);
         #1;
      end
      busReq    = 1'b1;
      busAddr   = addrWord;
      busDataIn = wrData;
      // T2, T3, then T4
      repeat (3) @(posedge clkT);
      // Sample mid T4, away from both edges
      @(negedge clkT);
      if (phase !== phaseT4)
      begin
         $display("ERROR: bus cycle sampled outside T4, phase %b", phase);
         errorCount++;
      end
      ack    = busAck;
      rdData = busDataOut;
      @(posedge clkT);
      #1;
      busReq    = 1'b0;
      busAddr   = '0;
      busDataIn = '0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic resetAndPhase();
      phase_t expPhase;
      int     k;
      startTest();
      if (phase !== phaseT1)
         reportWrong("resetAndPhase phase", {32'd0, phaseT1}, {32'd0, phase});
      // Valid read word on the bus, but no request
      busAddr = memAddrWord(flagRead, 22'd0);
      #1;
      if (busAck !== 1'b0)
         reportWrong("resetAndPhase busAck", 36'd0, {35'd0, busAck});
      busAddr = '0;
      // Two full rounds of the ring
      for (k = 1; k <= 8; k++)
      begin
         @(posedge clkT);
         #1;
         expPhase = 4'b0001 << (k % 4);
         if (phase !== expPhase)
            reportWrong("resetAndPhase ring", {32'd0, expPhase}, {32'd0, phase});
      end
      finishTest("resetAndPhase");
   endtask

   task automatic memWriteRead();
      logic [21:0] a;
      word_t       d;
      word_t       rd;
      logic        ack;
      int          i;
      startTest();
      for (i = 0; i < 12; i++)
      begin
         // Last write hits the first address again
         if (i == 11)
            a = usedAddr[0];
         else
            a = 22'(nextRandom() % (1 << memAddrWidth));
         d = randomWord();
         busCycle(memAddrWord(flagWrite, a), d, ack, rd);
         if (ack !== 1'b1)
            reportWrong("memWriteRead write ack", 36'd1, {35'd0, ack});
         shadowMem[int'(a)] = d;
         usedAddr.push_back(a);
      end
      foreach (usedAddr[j])
      begin
         busCycle(memAddrWord(flagRead, usedAddr[j]), '0, ack, rd);
         if (ack !== 1'b1)
            reportWrong("memWriteRead read ack", 36'd1, {35'd0, ack});
         if (rd !== shadowMem[int'(usedAddr[j])])
            reportWrong("memWriteRead data", shadowMem[int'(usedAddr[j])], rd);
      end
      finishTest("memWriteRead");
   endtask

   task automatic memWriteTest();
      word_t rd;
      logic  ack;
      int    i;
      startTest();
      for (i = 0; i < 4; i++)
      begin
         // Fresh data on the bus must not reach memory
         busCycle(memAddrWord(flagWrTest, usedAddr[i]), randomWord(), ack, rd);
         if (ack !== 1'b1)
            reportWrong("memWriteTest ack", 36'd1, {35'd0, ack});
         if (rd !== shadowMem[int'(usedAddr[i])])
            reportWrong("memWriteTest data", shadowMem[int'(usedAddr[i])], rd);
         busCycle(memAddrWord(flagRead, usedAddr[i]), '0, ack, rd);
         if (rd !== shadowMem[int'(usedAddr[i])])
            reportWrong("memWriteTest readback", shadowMem[int'(usedAddr[i])], rd);
      end
      finishTest("memWriteTest");
   endtask

   task automatic hsbAccess();
      logic [21:0] a;
      word_t       d;
      word_t       rd;
      logic        ack;
      int          i;
      startTest();
      // Main memory words sharing the HSB low bits
      for (i = 0; i < 4; i++)
      begin
         d = randomWord();
         busCycle(memAddrWord(flagWrite, 22'(i)), d, ack, rd);
         shadowMem[i] = d;
      end
      for (i = 0; i < hsbWords; i++)
      begin
         a = addrHsb + 22'(i);
         d = randomWord();
         busCycle(memAddrWord(flagWrite, a), d, ack, rd);
         if (ack !== 1'b1)
            reportWrong("hsbAccess write ack", 36'd1, {35'd0, ack});
         shadowHsb[i] = d;
      end
      for (i = 0; i < hsbWords; i++)
      begin
         a = addrHsb + 22'(i);
         busCycle(memAddrWord(flagRead, a), '0, ack, rd);
         if (ack !== 1'b1)
            reportWrong("hsbAccess read ack", 36'd1, {35'd0, ack});
         if (rd !== shadowHsb[i])
            reportWrong("hsbAccess data", shadowHsb[i], rd);
      end
      // Low main memory left alone
      for (i = 0; i < 4; i++)
      begin
         busCycle(memAddrWord(flagRead, 22'(i)), '0, ack, rd);
         if (rd !== shadowMem[i])
            reportWrong("hsbAccess main memory", shadowMem[i], rd);
      end
      finishTest("hsbAccess");
   endtask

   task automatic msrAccess();
      word_t d;
      word_t rd;
      logic  ack;
      startTest();
      d = randomWord();
      // Keep NXM clear so only the masked field shows
      d[msrNxmBit] = 1'b0;
      busCycle(ioAddrWord(flagWrite, memDev, addrMsr), d, ack, rd);
      if (ack !== 1'b1)
         reportWrong("msrAccess write ack", 36'd1, {35'd0, ack});
      shadowMsr = d & msrWriteMask;
      busCycle(ioAddrWord(flagRead, memDev, addrMsr), '0, ack, rd);
      if (ack !== 1'b1)
         reportWrong("msrAccess read ack", 36'd1, {35'd0, ack});
      if (rd !== shadowMsr)
         reportWrong("msrAccess data", shadowMsr, rd);
      // Wrong device, then wrong register
      busCycle(ioAddrWord(flagRead, 4'd1, addrMsr), '0, ack, rd);
      if (ack !== 1'b0)
         reportWrong("msrAccess other device ack", 36'd0, {35'd0, ack});
      busCycle(ioAddrWord(flagRead, memDev, addrMsr + 18'd1), '0, ack, rd);
      if (ack !== 1'b0)
         reportWrong("msrAccess other address ack", 36'd0, {35'd0, ack});
      finishTest("msrAccess");
   endtask

   task automatic nxmReport();
      word_t rd;
      logic  ack;
      startTest();
      // Above 32K words and below the HSB
      busCycle(memAddrWord(flagRead, 22'o0200000), '0, ack, rd);
      if (ack !== 1'b0)
         reportWrong("nxmReport ack", 36'd0, {35'd0, ack});
      shadowMsr[msrNxmBit] = 1'b1;
      busCycle(ioAddrWord(flagRead, memDev, addrMsr), '0, ack, rd);
      if (rd !== shadowMsr)
         reportWrong("nxmReport flag set", shadowMsr, rd);
      // Writing zero clears the flag and the field
      busCycle(ioAddrWord(flagWrite, memDev, addrMsr), '0, ack, rd);
      if (ack !== 1'b1)
         reportWrong("nxmReport clear ack", 36'd1, {35'd0, ack});
      shadowMsr = '0;
      busCycle(ioAddrWord(flagRead, memDev, addrMsr), '0, ack, rd);
      if (rd !== shadowMsr)
         reportWrong("nxmReport flag cleared", shadowMsr, rd);
      finishTest("nxmReport");
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      rngState    = 32'd25683;
      errorCount  = 0;
      testCount   = 0;
      failedTests = 0;
      cycleCount  = 0;
      shadowMsr   = '0;
      rst         = 1'b1;
      busReq      = 1'b0;
      busAddr     = '0;
      busDataIn   = '0;
      repeat (4) @(posedge clkT);
      #1;
      rst = 1'b0;

      resetAndPhase();
      memWriteRead();
      memWriteTest();
      hsbAccess();
      msrAccess();
      nxmReport();

      $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
      if (errorCount == 0)
      begin
         $display("TESTS PASSED");
      end
      else
      begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/ks10Mem.sv
// Memory subsystem top level joining timing, control, array and status
`default_nettype none
`timescale 1ns/1ps

module ks10Mem
   import ks10MemPkg::*;
#(
   parameter int memAddrWidth = 15
)
(
   input  wire      clkT,
   input  wire      rst,
   input  wire      busReq,
   input  busAddr_u busAddr,
   input  word_t    busDataIn,
   output logic     busAck,
   output word_t    busDataOut,
   output phase_t   phase
);

   // Internal strobes and data
   word_t arrayData;
   word_t msrData;
   logic  memWe;
   logic  hsbWe;
   logic  msrWe;
   logic  nxm;
   logic  memSel;

   // T1-T4 sequencer
   memTiming timing (
      .clkT  (clkT),
      .rst   (rst),
      .phase (phase)
   );

   // Decode and bus handshake
   memCtrl #(
      .memAddrWidth (memAddrWidth)
   ) ctrl (
      .clkT       (clkT),
      .rst        (rst),
      .phase      (phase),
      .busReq     (busReq),
      .busAddr    (busAddr),
      .arrayData  (arrayData),
      .msrData    (msrData),
      .busAck     (busAck),
      .busDataOut (busDataOut),
      .memWe      (memWe),
      .hsbWe      (hsbWe),
      .msrWe      (msrWe),
      .nxm        (nxm),
      .memSel     (memSel),
      .ioSel      ()
   );

   // Main RAM and HSB
   memArray #(
      .memAddrWidth (memAddrWidth)
   ) array (
      .clkT    (clkT),
      .phase   (phase),
      .addr    (busAddr.memView.addr),
      .dataIn  (busDataIn),
      .memWe   (memWe),
      .hsbWe   (hsbWe),
      .memSel  (memSel),
      .dataOut (arrayData)
   );

   // Memory Status Register
   memStat stat (
      .clkT    (clkT),
      .rst     (rst),
      .dataIn  (busDataIn),
      .msrWe   (msrWe),
      .nxm     (nxm),
      .msrData (msrData)
   );

endmodule

`default_nettype wire

//--- verilog/mem/memCtrl.sv
// Bus word decode, target select, acknowledge and read data mux
`default_nettype none
`timescale 1ns/1ps

module memCtrl
   import ks10MemPkg::*;
#(
   parameter int memAddrWidth = 15
)
(
   input  wire      clkT,
   input  wire      rst,
   input  phase_t   phase,
   input  wire      busReq,
   input  busAddr_u busAddr,
   input  word_t    arrayData,
   input  word_t    msrData,
   output logic     busAck,
   output word_t    busDataOut,
   output logic     memWe,
   output logic     hsbWe,
   output logic     msrWe,
   output logic     nxm,
   output logic     memSel,
   output logic     ioSel
);

   ////////////////////////////////////////////////////////////////////////////
   // Flag decode
   ////////////////////////////////////////////////////////////////////////////

   logic isRead;
   logic isWrTest;
   logic isWrite;
   logic isPhys;
   logic isIo;

   // Flags sit in the same place in both views
   assign isRead   = busAddr.memView.flags[flagRead];
   assign isWrTest = busAddr.memView.flags[flagWrTest];
   assign isWrite  = busAddr.memView.flags[flagWrite];
   assign isPhys   = busAddr.memView.flags[flagPhys];
   assign isIo     = busAddr.memView.flags[flagIo];

   ////////////////////////////////////////////////////////////////////////////
   // Target decode
   ////////////////////////////////////////////////////////////////////////////

   logic msrHit;
   logic memValid;
   logic hsbMatch;
   logic memRef;
   logic memHit;
   logic hsbHit;
   logic t3;

   // I/O view: our device, MSR register
   assign msrHit = isIo & isPhys & (busAddr.ioView.dev == memDev) &
                   (busAddr.ioView.addr == addrMsr);

   // Memory view: nothing above the implemented address bits
   assign memValid = ((busAddr.memView.addr >> memAddrWidth) == '0);

   // HSB block, low 5 bits select the word
   assign hsbMatch = (busAddr.memView.addr[14:30] == addrHsb[14:30]);

   // Any memory cycle type
   assign memRef = ~isIo & (isRead | isWrite | isWrTest);

   // Main memory takes priority if the two ever overlap
   assign memHit = memRef & memValid;
   assign hsbHit = memRef & hsbMatch & ~memValid;

   assign t3 = phase[2];

   ////////////////////////////////////////////////////////////////////////////
   // Acknowledge and strobes
   ////////////////////////////////////////////////////////////////////////////

   // Combinational, follows busReq
   // Write-test acks like a read
   assign busAck = busReq & ((msrHit & (isRead | isWrite)) | memHit | hsbHit);

   // Writes land on the edge ending T3
   assign memWe = busReq & t3 & memHit & isWrite;
   assign hsbWe = busReq & t3 & hsbHit & isWrite;
   assign msrWe = busReq & t3 & msrHit & isWrite;

   // Unclaimed memory reference
   // One-clock pulse to the MSR
   assign nxm = busReq & t3 & memRef & ~memValid & ~hsbMatch;

   ////////////////////////////////////////////////////////////////////////////
   // Read data select
   ////////////////////////////////////////////////////////////////////////////

   // Source latched at T3, held through T4
   always_ff @(posedge clkT)
   begin
      if (rst)
      begin
         memSel <= 1'b0;
         ioSel  <= 1'b0;
      end
      else if (t3)
      begin
         memSel <= memHit;
         ioSel  <= busReq & msrHit;
      end
   end

   // Array already picks main RAM or HSB on memSel
   assign busDataOut = ioSel ? msrData : arrayData;

   // Only one RAM may be written per cycle
   weExclusive : assert property (@(posedge clkT) disable iff (rst)
      !(memWe && hsbWe));

endmodule

`default_nettype wire

//--- verilog/mem/memArray.sv
// Main block RAM and Halt Status Block RAM with T3 writes and registered read address
`default_nettype none
`timescale 1ns/1ps

module memArray
   import ks10MemPkg::*;
#(
   parameter int memAddrWidth = 15
)
(
   input  wire          clkT,
   input  phase_t       phase,
   input  logic [14:35] addr,
   input  word_t        dataIn,
   input  wire          memWe,
   input  wire          hsbWe,
   input  wire          memSel,
   output word_t        dataOut
);

   // HSB index width, 5 bits for 32 words
   localparam int hsbIdxWidth = $clog2(hsbWords);

   ////////////////////////////////////////////////////////////////////////////
   // Address slices
   ////////////////////////////////////////////////////////////////////////////

   logic [memAddrWidth-1:0] memIdx;
   logic [hsbIdxWidth-1:0]  hsbIdx;

   // Low bits of the word address index each RAM
   assign memIdx = addr[36-memAddrWidth:35];
   assign hsbIdx = addr[36-hsbIdxWidth:35];

   ////////////////////////////////////////////////////////////////////////////
   // Main memory
   ////////////////////////////////////////////////////////////////////////////

   word_t                   mainRam [0:(1 << memAddrWidth)-1];
   logic [memAddrWidth-1:0] rdMemIdx;

   // Write on enable, already gated to T3
   // Read address captured on the same edge for T4 data
   always_ff @(posedge clkT)
   begin
      if (memWe)
      begin
         mainRam[memIdx] <= dataIn;
      end
      if (phase[2])
      begin
         rdMemIdx <= memIdx;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Halt Status Block
   ////////////////////////////////////////////////////////////////////////////

   word_t                  hsbRam [0:hsbWords-1];
   logic [hsbIdxWidth-1:0] rdHsbIdx;

   // Same scheme as main memory, separate 32-word store
   always_ff @(posedge clkT)
   begin
      if (hsbWe)
      begin
         hsbRam[hsbIdx] <= dataIn;
      end
      if (phase[2])
      begin
         rdHsbIdx <= hsbIdx;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read data
   ////////////////////////////////////////////////////////////////////////////

   // memSel was latched at T3, stable through T4
   assign dataOut = memSel ? mainRam[rdMemIdx] : hsbRam[rdHsbIdx];

   // Control must only strobe writes in T3
   // Read address capture relies on the same edge
   weInT3 : assert property (@(posedge clkT)
      (memWe || hsbWe) |-> (phase == phaseT3));

endmodule

`default_nettype wire

//--- verilog/mem/memStat.sv
// Memory Status Register with writable field and sticky NXM flag
`default_nettype none
`timescale 1ns/1ps

module memStat
   import ks10MemPkg::*;
(
   input  wire   clkT,
   input  wire   rst,
   input  word_t dataIn,
   input  wire   msrWe,
   input  wire   nxm,
   output word_t msrData
);

   ////////////////////////////////////////////////////////////////////////////
   // Next register value
   ////////////////////////////////////////////////////////////////////////////

   word_t msrReg;
   word_t msrNext;

   always_comb
   begin
      // Hold by default
      msrNext = msrReg;

      // Write stores the field through the mask
      if (msrWe)
      begin
         msrNext = dataIn & msrWriteMask;
         // NXM bit taken straight from the data
         // Writing 0 clears it
         msrNext[msrNxmBit] = dataIn[msrNxmBit];
      end

      // NXM report wins over a write in the same clock
      if (nxm)
      begin
         msrNext[msrNxmBit] = 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Register
   ////////////////////////////////////////////////////////////////////////////

   // Updates on the edge ending T3, like memory writes
   always_ff @(posedge clkT)
   begin
      if (rst)
      begin
         msrReg <= '0;
      end
      else
      begin
         msrReg <= msrNext;
      end
   end

   // Read back path
   assign msrData = msrReg;

endmodule

`default_nettype wire

//--- verilog/mem/memTiming.sv
// Four-phase T1-T4 bus cycle generator
`default_nettype none
`timescale 1ns/1ps

module memTiming
   import ks10MemPkg::*;
(
   input  wire    clkT,
   input  wire    rst,
   output phase_t phase
);

   ////////////////////////////////////////////////////////////////////////////
   // Phase ring
   ////////////////////////////////////////////////////////////////////////////

   // Single hot bit walks T1 -> T2 -> T3 -> T4 -> T1
   always_ff @(posedge clkT)
   begin
      if (rst)
      begin
         phase <= phaseT1;
      end
      else
      begin
         // Rotate left, T4 wraps back to T1
         phase <= {phase[2:0], phase[3]};
      end
   end

   // Ring must never lose or gain a bit
   // Control and array both key off single phase bits
   phaseOneHot : assert property (@(posedge clkT) disable iff (rst)
      $onehot(phase));

endmodule

`default_nettype wire

//--- common/ks10MemPkg.sv
// Bus word types, address union, flag positions and memory subsystem addresses
`default_nettype none

package ks10MemPkg;

   ////////////////////////////////////////////////////////////////////////////
   // Bus data and phase
   ////////////////////////////////////////////////////////////////////////////

   // 36-bit backplane word, bit 0 is the MSB
   typedef logic [0:35] word_t;

   // One-hot bus phase
   // Bit 0 is T1, bit 3 is T4
   typedef logic [3:0] phase_t;

   localparam phase_t phaseT1 = 4'b0001;
   localparam phase_t phaseT2 = 4'b0010;
   localparam phase_t phaseT3 = 4'b0100;
   localparam phase_t phaseT4 = 4'b1000;

   ////////////////////////////////////////////////////////////////////////////
   // Bus address word
   ////////////////////////////////////////////////////////////////////////////

   // Same 36 bits seen two ways
   // Flags in 0..13 are shared by both views
   typedef union packed
   {
      // Memory reference, 22-bit word address
      struct packed
      {
         logic [0:13]  flags;
         logic [14:35] addr;
      } memView;
      // I/O reference, device and 18-bit register address
      struct packed
      {
         logic [0:13]  flags;
         logic [14:17] dev;
         logic [18:35] addr;
      } ioView;
   } busAddr_u;

   // Flag positions, numbered like the bus word
   localparam int unsigned flagRead   = 3;
   localparam int unsigned flagWrTest = 4;
   localparam int unsigned flagWrite  = 5;
   localparam int unsigned flagIo     = 6;
   localparam int unsigned flagPhys   = 8;

   ////////////////////////////////////////////////////////////////////////////
   // Memory controller addresses
   ////////////////////////////////////////////////////////////////////////////

   // Memory controller sits on device 0
   localparam logic [14:17] memDev = 4'd0;

   // Memory Status Register I/O address
   localparam logic [18:35] addrMsr = 18'o100000;

   // Halt Status Block base
   // Only bits 14..30 are compared, low 5 bits pick the word
   localparam logic [14:35] addrHsb = 22'o0376000;

   // HSB depth in words
   localparam int unsigned hsbWords = 32;

   ////////////////////////////////////////////////////////////////////////////
   // Memory Status Register layout
   ////////////////////////////////////////////////////////////////////////////

   // Sticky non-existent-memory flag
   // Set by hardware, cleared by writing 0
   localparam int unsigned msrNxmBit = 2;

   // Plain read/write field, bits 5..17
   // Does not cover the NXM bit
   localparam word_t msrWriteMask = 36'o017777_000000;

endpackage

`default_nettype wire
